// File: tb/recip_stimulus.txt
# ce in_valid din expected_dout (din and expected_dout in hex, 1.23 format)
# expected_dout is used only on lines where ce and in_valid are both 1
1 1 800000 7FFFE0
1 1 FFFFFF 3FFFFC
1 1 800001 7FFFDF
1 1 FF8000 40200C
1 1 C00000 555550
1 1 A00000 666658
1 1 E00000 49248C
1 1 900000 71C702
1 1 880000 78785E
1 1 B00000 5D1735
1 0 000000 000000
1 0 000000 000000
1 0 000000 000000
1 0 000000 000000
1 0 000000 000000
1 1 C00000 555550
1 0 123456 000000
1 1 A00000 666658
1 0 000000 000000
1 1 E00000 49248C
1 0 000000 000000
1 0 000000 000000
1 1 900000 71C702
1 0 FFFFFF 000000
1 0 000000 000000
1 0 000000 000000
1 0 000000 000000
1 1 880000 78785E
1 1 B00000 5D1735
0 1 FFFFFF 000000
0 1 FFFFFF 000000
0 0 000000 000000
1 1 800000 7FFFE0
0 0 000000 000000
1 1 FFFFFF 3FFFFC
1 0 000000 000000
0 0 000000 000000
0 0 000000 000000
1 0 000000 000000
1 0 000000 000000
0 0 000000 000000
0 1 A00000 000000
0 0 000000 000000
1 0 000000 000000
1 0 000000 000000
1 1 C00000 555550
0 1 C00000 000000
1 1 A00000 666658
0 1 A00000 000000
1 1 E00000 49248C
0 0 000000 000000
1 1 900000 71C702
1 1 880000 78785E
0 1 B00000 000000
1 1 B00000 5D1735
1 1 800001 7FFFDF
1 1 FF8000 40200C
0 0 000000 000000
0 0 000000 000000
1 1 800000 7FFFE0
1 1 800000 7FFFE0
1 0 000000 000000
1 1 FFFFFF 3FFFFC
1 0 000000 000000
0 0 000000 000000
1 1 E00000 49248C
0 0 000000 000000
1 1 FF8000 40200C
1 1 C00000 555550
0 0 000000 000000

// File: src.f
design/recip_pkg.sv
design/recip_seed_lut.sv
design/recip_nr_correct.sv
design/recip_nr_refine.sv
design/recip_round.sv
design/recip_nr_top.sv
tb/tb_recip_nr.sv

// File: Bender.yml
package:
  name: recip_nr

sources:
  - files:
      - design/recip_pkg.sv
      - design/recip_seed_lut.sv
      - design/recip_nr_correct.sv
      - design/recip_nr_refine.sv
      - design/recip_round.sv
      - design/recip_nr_top.sv

  - target: test
    files:
      - tb/tb_recip_nr.sv

// File: tb/tb_recip_nr.sv
`timescale 1ns/1ns

module tb_recip_nr;

	// ==================================================
	// Constants
	// ==================================================
	localparam int CLK_HALF    = 50;                          // 100 ns period
	localparam int RST_CYCLES  = 4;                           // Reset length in clocks
	localparam int LATENCY     = 4;                           // ce edges from accept to dout
	localparam int DRAIN_LIMIT = 50;                          // Final drain timeout, clocks
	localparam int MAX_LINES   = 1000;                        // Guard on file length
	localparam int ACC_TOL     = 48;                          // Squared seed error of one NR step
	localparam int FRAC_OUT    = recip_pkg::WLO - 1;          // 23 fraction bits
	localparam int ONE_SH      = (recip_pkg::WL - 1) + FRAC_OUT;  // 1.0 in 2.46
	localparam STIM_FILE       = "tb/recip_stimulus.txt";

	typedef struct packed {
		logic [2:0]                left;                      // ce edges still to go
		logic [recip_pkg::WL-1:0]  din;                       // Operand
		logic [recip_pkg::WLO-1:0] want;                      // Result from the file
	} item_t;

	logic                      CLK;
	logic                      nRST;
	logic                      ce;
	logic                      in_valid;
	logic [recip_pkg::WL-1:0]  din;
	logic [recip_pkg::WLO-1:0] dout;
	logic                      out_valid;
	logic [recip_pkg::WLO-1:0] want_in;                       // Expected value of line on din

	item_t                     in_flight [$];                 // Oldest first
	logic                      model_on;                      // Set by first reset edge
	logic                      want_valid;                    // Model of out_valid
	logic [recip_pkg::WLO-1:0] want_dout;                     // Model of dout
	logic                      due;                           // Item left at last edge
	logic [recip_pkg::WL-1:0]  due_din;                       // Its operand
	logic                      stepped;                       // Last edge had ce high
	int                        checks;
	int                        value_errors;
	int                        other_errors;
	int                        accepted;
	int                        delivered;

	recip_nr_top i_recip_nr_top (
		.CLK       (CLK),
		.nRST      (nRST),
		.ce        (ce),
		.in_valid  (in_valid),
		.din       (din),
		.dout      (dout),
		.out_valid (out_valid)
	);

	always #(CLK_HALF) CLK = ~CLK;

	// ==================================================
	// Output model, steps on ce edges
	// ==================================================
	always @(posedge CLK) begin : out_model
		item_t it;
		int    k;
		if (!nRST) begin
			in_flight.delete();
			want_valid = 1'b0;
			want_dout  = '0;                                  // Output register cleared
			due        = 1'b0;
			stepped    = 1'b0;
			model_on   = 1'b1;
		end else begin
			due     = 1'b0;
			stepped = ce;
			if (ce) begin
				for (k = 0; k < in_flight.size(); k++) begin
					it           = in_flight[k];
					it.left      = it.left - 3'd1;              // One more edge passed
					in_flight[k] = it;
				end
				if (in_valid) begin
					it.left = 3'(LATENCY - 1);                  // Accepting edge counts
					it.din  = din;
					it.want = want_in;
					in_flight.push_back(it);
					accepted++;
				end
				want_valid = 1'b0;                            // Bubble unless an item is due
				if (in_flight.size() != 0) begin
					it = in_flight[0];
					if (it.left == 3'd0) begin
						it         = in_flight.pop_front();
						want_valid = 1'b1;
						want_dout  = it.want;
						due_din    = it.din;
						due        = 1'b1;
					end
				end
			end
		end
	end

	// |dout*din - 1.0| in 2.46 units
	task automatic check_accuracy(input logic [recip_pkg::WL-1:0] x,
			input logic [recip_pkg::WLO-1:0] y);
		longint prod;
		longint err;
		prod = longint'(x) * longint'(y);
		err  = prod - (longint'(1) << ONE_SH);
		if (err < 0) begin
			err = -err;
		end
		assert (err <= (longint'(ACC_TOL) << FRAC_OUT)) else begin
			$display("CHECK FAILED at %0t: dout*din error expected <= %0d LSB, actual %0d LSB",
				$time, ACC_TOL, err >> FRAC_OUT);
			value_errors++;
		end
	endtask

	// Runs half a period after the edge when outputs are settled
	task automatic check_outputs();
		if (model_on) begin
			checks++;
			assert (out_valid === want_valid) else begin
				$display("CHECK FAILED at %0t: out_valid expected %b, actual %b",
					$time, want_valid, out_valid);
				value_errors++;
			end
			assert (dout === want_dout) else begin
				$display("CHECK FAILED at %0t: dout expected %h, actual %h",
					$time, want_dout, dout);
				value_errors++;
			end
			if (stepped && out_valid === 1'b1) begin
				delivered++;                                  // Result seen on the DUT side
			end
			if (due) begin
				check_accuracy(due_din, dout);
			end
		end
	endtask

	// ==================================================
	// Stimulus from file, one line per falling edge
	// ==================================================
	initial begin : main
		int    fd;
		int    n;
		int    lines;
		int    wait_cycles;
		int    v_ce;
		int    v_valid;
		string line;
		logic [recip_pkg::WL-1:0]  v_din;
		logic [recip_pkg::WLO-1:0] v_want;
		CLK          = 1'b0;
		nRST         = 1'b0;
		ce           = 1'b0;
		in_valid     = 1'b0;
		din          = '0;
		want_in      = '0;
		model_on     = 1'b0;
		due          = 1'b0;
		stepped      = 1'b0;
		checks       = 0;
		value_errors = 0;
		other_errors = 0;
		accepted     = 0;
		delivered    = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %s", STIM_FILE);
			other_errors++;
		end
		repeat (RST_CYCLES) begin
			@(negedge CLK);
			check_outputs();                                  // Outputs cleared in reset
		end
		nRST  = 1'b1;
		lines = 0;
		while (fd != 0 && lines < MAX_LINES) begin
			lines++;
			if ($fgets(line, fd) == 0) begin
				break;                                        // End of file
			end
			if (line.len() > 0 && line.substr(0, 0) == "#") begin
				continue;                                     // Column legend
			end
			n = $sscanf(line, "%d %d %h %h", v_ce, v_valid, v_din, v_want);
			if (n != 4) begin
				if (line.len() > 1) begin
					$display("Stimulus line %0d could not be parsed", lines);
					other_errors++;
				end
				continue;
			end
			@(negedge CLK);
			check_outputs();
			ce       = v_ce[0];
			in_valid = v_valid[0];
			din      = v_din;
			want_in  = v_want;
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		@(negedge CLK);
		check_outputs();
		ce          = 1'b1;                                   // Flush what is left
		in_valid    = 1'b0;
		din         = '0;
		want_in     = '0;
		wait_cycles = 0;
		while (in_flight.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
			@(negedge CLK);
			check_outputs();
			wait_cycles++;
		end
		if (in_flight.size() != 0) begin
			$display("Drain timed out with %0d results still missing", in_flight.size());
			other_errors++;
		end
		assert (delivered == accepted) else begin
			$display("Accepted %0d inputs but saw %0d results", accepted, delivered);
			other_errors++;
		end
		$display("Checks %0d, value errors %0d, other errors %0d, results %0d",
			checks, value_errors, other_errors, delivered);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: design/recip_nr_top.sv
`timescale 1ns/1ns

module recip_nr_top (
	input  logic                      CLK,        // System clock
	input  logic                      nRST,       // Sync reset, active low
	input  logic                      ce,         // Global advance, also back-pressure
	input  logic                      in_valid,   // din carries an item
	input  logic [recip_pkg::WL-1:0]  din,        // Significand, 1.23 in [1, 2)
	output logic [recip_pkg::WLO-1:0] dout,       // Reciprocal, 1.23
	output logic                      out_valid   // dout carries a result
);

	recip_pkg::seed_stage_t   s1;                 // Table -> correction
	recip_pkg::corr_stage_t   s2;                 // Correction -> refine
	recip_pkg::refine_stage_t s3;                 // Refine -> round

	// ==================================================
	// Four stages, one ce edge each
	// ==================================================
	recip_seed_lut i_seed_lut (
		.CLK      (CLK),
		.nRST     (nRST),
		.ce       (ce),
		.in_valid (in_valid),
		.din      (din),
		.seed_out (s1)
	);

	recip_nr_correct i_nr_correct (
		.CLK      (CLK),
		.nRST     (nRST),
		.ce       (ce),
		.seed_in  (s1),
		.corr_out (s2)
	);

	recip_nr_refine i_nr_refine (
		.CLK      (CLK),
		.nRST     (nRST),
		.ce       (ce),
		.corr_in  (s2),
		.prod_out (s3)
	);

	recip_round i_round (
		.CLK       (CLK),
		.nRST      (nRST),
		.ce        (ce),
		.prod_in   (s3),
		.dout      (dout),
		.out_valid (out_valid)
	);

endmodule

// File: design/recip_round.sv
`timescale 1ns/1ns

module recip_round (
	input  logic                     CLK,        // System clock
	input  logic                     nRST,       // Sync reset, active low
	input  logic                     ce,         // Pipeline advance
	input  recip_pkg::refine_stage_t prod_in,    // From refine stage
	output logic [recip_pkg::WLO-1:0] dout,      // Reciprocal, 1.23
	output logic                     out_valid   // Result present
);

	localparam int HI = recip_pkg::WLO + recip_pkg::ROUND_BITS;  // First bit above 1.23 field

	// Half an output LSB
	localparam logic [recip_pkg::PROD_W:0] HALF_LSB = 1 << (recip_pkg::ROUND_BITS - 1);

	logic [recip_pkg::PROD_W:0]  sum;        // Product plus half LSB, carry kept
	logic                        sat;        // Rounded value at or above 2.0
	logic [recip_pkg::WLO-1:0]   rounded;    // Final 1.23 value

	// ==================================================
	// Round to nearest and saturate
	// ==================================================
	assign sum     = {1'b0, prod_in.prod} + HALF_LSB;
	assign sat     = |sum[recip_pkg::PROD_W:HI];              // Integer part 2 or more
	assign rounded = sat ? '1 : sum[HI-1:recip_pkg::ROUND_BITS];

	always_ff @(posedge CLK) begin
		if (!nRST) begin
			out_valid <= 1'b0;
			dout      <= '0;                      // Zero until first result
		end else if (ce) begin
			out_valid <= prod_in.valid;
			if (prod_in.valid) begin
				dout <= rounded;                  // Bubbles keep last result
			end
		end
	end

	// Stall must freeze the output side
	a_no_rise_stall: assert property (@(posedge CLK) disable iff (!nRST)
		!ce |=> !$rose(out_valid))
		else $error("out_valid rose during a stall");

endmodule

// File: design/recip_nr_refine.sv
`timescale 1ns/1ns

module recip_nr_refine (
	input  logic                     CLK,       // System clock
	input  logic                     nRST,      // Sync reset, active low
	input  logic                     ce,        // Pipeline advance
	input  recip_pkg::corr_stage_t   corr_in,   // From correction stage
	output recip_pkg::refine_stage_t prod_out   // To rounding stage
);

	logic [recip_pkg::PROD_W-1:0] prod;         // seed * corr
	logic                         valid_q;      // Stage valid
	logic [recip_pkg::PROD_W-1:0] prod_q;       // Registered product

	// ==================================================
	// Second multiply, one Newton-Raphson step
	// ==================================================
	// y1 = y0 * (2 - x*y0), full width 2.36
	assign prod = corr_in.seed * corr_in.corr;  // 1.11 * 1.25

	always_ff @(posedge CLK) begin
		if (!nRST) begin
			valid_q <= 1'b0;
		end else if (ce) begin
			valid_q <= corr_in.valid;           // Follow the item
		end
	end

	always_ff @(posedge CLK) begin
		if (ce) begin
			prod_q <= prod;                     // No truncation here
		end
	end

	assign prod_out = '{valid: valid_q, prod: prod_q};

endmodule

// File: design/recip_nr_correct.sv
`timescale 1ns/1ns

module recip_nr_correct (
	input  logic                   CLK,       // System clock
	input  logic                   nRST,      // Sync reset, active low
	input  logic                   ce,        // Pipeline advance
	input  recip_pkg::seed_stage_t seed_in,   // From table stage
	output recip_pkg::corr_stage_t corr_out   // To refine stage
);

	localparam int PW = recip_pkg::WL + recip_pkg::LUT_BITS;  // x*seed width, 2.34

	logic [PW-1:0]                  prod;                     // x * seed
	logic [recip_pkg::DWL-1:0]      prod_t;                   // Truncated to 1.25
	logic                           valid_q;                  // Stage valid
	logic [recip_pkg::LUT_BITS-1:0] seed_q;                   // Seed forwarded
	logic [recip_pkg::DWL-1:0]      corr_q;                   // Correction term

	// ==================================================
	// First multiply and correction term
	// ==================================================
	assign prod = seed_in.x * seed_in.seed;                   // 1.23 * 1.11

	// Drop the 2.0 bit, keep 1.25, truncate the tail
	assign prod_t = prod[PW-2 -: recip_pkg::DWL];

	always_ff @(posedge CLK) begin
		if (!nRST) begin
			valid_q <= 1'b0;
		end else if (ce) begin
			valid_q <= seed_in.valid;                         // Follow the item
		end
	end

	always_ff @(posedge CLK) begin
		if (ce) begin
			seed_q <= seed_in.seed;                           // Needed again in stage 3
			corr_q <= ~prod_t;                                // 2 - p - 1 LSB
		end
	end

	assign corr_out = '{valid: valid_q, seed: seed_q, corr: corr_q};

	// Seed from stage 1 keeps x*seed below 2.0, so the dropped bit is zero
	a_prod_lt2: assert property (@(posedge CLK) disable iff (!nRST)
		(ce && seed_in.valid) |-> !prod[PW-1])
		else $error("Seed times operand reached 2.0");

endmodule

// File: design/recip_seed_lut.sv
`timescale 1ns/1ns

module recip_seed_lut (
	input  logic                          CLK,       // System clock
	input  logic                          nRST,      // Sync reset, active low
	input  logic                          ce,        // Pipeline advance
	input  logic                          in_valid,  // Input item present
	input  logic [recip_pkg::WL-1:0]      din,       // Significand, 1.23
	output recip_pkg::seed_stage_t        seed_out   // To correction stage
);

	localparam int DEPTH = 2 ** recip_pkg::ADDR_BITS;        // Table entries

	logic [recip_pkg::LUT_BITS-1:0]  seed_rom [DEPTH];       // Seed table
	logic [recip_pkg::ADDR_BITS-1:0] addr;                   // Table index
	logic                            valid_q;                // Stage valid
	logic [recip_pkg::WL-1:0]        x_q;                    // Captured operand
	logic [recip_pkg::LUT_BITS-1:0]  seed_q;                 // Captured seed

	// ==================================================
	// Table, built at elaboration
	// ==================================================
	for (genvar g = 0; g < DEPTH; g++) begin : g_rom
		assign seed_rom[g] = recip_pkg::seed_of(g);          // Constant entry
	end

	// Fraction bits just below the leading one
	assign addr = din[recip_pkg::WL-2 -: recip_pkg::ADDR_BITS];

	always_ff @(posedge CLK) begin
		if (!nRST) begin
			valid_q <= 1'b0;                                 // Empty pipe
		end else if (ce) begin
			valid_q <= in_valid;                             // Bubbles pass as invalid
		end
	end

	always_ff @(posedge CLK) begin
		if (ce) begin
			x_q    <= din;                                   // Operand for stage 2
			seed_q <= seed_rom[addr];                        // Lookup
		end
	end

	assign seed_out = '{valid: valid_q, x: x_q, seed: seed_q};

	// Accepted operand must be normalized, lands in x next edge
	a_lead_one: assert property (@(posedge CLK) disable iff (!nRST)
		(ce && in_valid) |=> seed_out.x[recip_pkg::WL-1])
		else $error("Accepted din without leading one");

endmodule

// File: design/recip_pkg.sv
package recip_pkg;

	// ==================================================
	// Widths and fixed-point formats
	// ==================================================
	localparam int WL         = 24;                    // Input width, 1.23
	localparam int WLO        = 24;                    // Output width, 1.23
	localparam int ADDR_BITS  = 8;                     // Table address, fraction bits below lead one
	localparam int LUT_BITS   = 12;                    // Seed width, 1.11
	localparam int DWL        = 26;                    // Correction term width, 1.25
	localparam int PROD_W     = LUT_BITS + DWL;        // Refine product, 2.36
	localparam int ROUND_BITS = PROD_W - WLO - 1;      // Low bits dropped by rounding

	// ==================================================
	// Stage registers
	// ==================================================
	typedef struct packed {
		logic                valid;                    // Item present
		logic [WL-1:0]       x;                        // Operand, 1.23
		logic [LUT_BITS-1:0] seed;                     // Table seed, 1.11
	} seed_stage_t;

	typedef struct packed {
		logic                valid;                    // Item present
		logic [LUT_BITS-1:0] seed;                     // Seed carried forward
		logic [DWL-1:0]      corr;                     // 2 - x*seed, 1.25
	} corr_stage_t;

	typedef struct packed {
		logic                valid;                    // Item present
		logic [PROD_W-1:0]   prod;                     // Refined reciprocal, 2.36
	} refine_stage_t;

	// ==================================================
	// Seed table rule
	// ==================================================
	// Entry i covers [1 + i/2^ADDR_BITS, 1 + (i+1)/2^ADDR_BITS).
	// The seed is the reciprocal of the interval midpoint:
	//   mid  = (2^(ADDR_BITS+1) + 2i + 1) / 2^(ADDR_BITS+1)
	//   seed = 2^(LUT_BITS-1) / mid, rounded to nearest
	function automatic logic [LUT_BITS-1:0] seed_of(input int i);
		longint num;                                   // Scaled numerator
		longint den;                                   // Midpoint in units of half an interval
		longint q;                                     // Rounded quotient
		longint q_max;                                 // All-ones 1.11
		num   = longint'(1) << (LUT_BITS + ADDR_BITS);
		den   = (longint'(1) << (ADDR_BITS + 1)) + 2 * longint'(i) + 1;
		q     = (num + den / 2) / den;                 // Round to nearest
		q_max = (longint'(1) << LUT_BITS) - 1;
		if (q > q_max) begin
			q = q_max;                                 // Clamp just below 2.0
		end
		return q[LUT_BITS-1:0];
	endfunction

endpackage
